// File: all.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_counters.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// File: hw/icache_counters.sv
`default_nettype none

module icache_counters (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          beat_clear,
    input  logic                          beat_inc,
    input  logic                          hit_event,
    input  logic                          miss_event,
    output logic [icache_pkg::offset_w-1:0] beat,
    output logic                          last_beat,
    output logic [icache_pkg::count_w-1:0]  hit_count,
    output logic [icache_pkg::count_w-1:0]  miss_count
);
    import icache_pkg::*;

    // refill beat, wraps back to zero after the last word
    always_ff @(posedge clk) begin
        if (reset_n) begin
            beat <= '0;
        end else if (beat_clear) begin
            beat <= '0;
        end else if (beat_inc) begin
            beat <= beat + 1'b1;
        end
    end

    assign last_beat = (beat == offset_w'(block_words - 1));

    // tallies saturate at all ones
    always_ff @(posedge clk) begin
        if (reset_n) begin
            hit_count <= '0;
        end else if (hit_event && (hit_count != {count_w{1'b1}})) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            miss_count <= '0;
        end else if (miss_event && (miss_count != {count_w{1'b1}})) begin
            miss_count <= miss_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  logic hit,
    input  logic mem_ack,
    input  logic last_beat,
    output logic accept,
    output logic cpu_ack,
    output logic mem_cyc,
    output logic mem_stb,
    output logic beat_clear,
    output logic beat_inc,
    output logic hit_event,
    output logic miss_event,
    output logic tag_write,
    output logic word_write
);
    import icache_pkg::*;

    logic [state_w-1:0] state;
    logic [state_w-1:0] state_next;

    // lookup entered from a refill answers the miss, so its hit is not tallied
    logic refilled;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= st_idle;
            refilled <= 1'b0;
        end else begin
            state <= state_next;
            if (tag_write) begin
                refilled <= 1'b1;
            end else if (state == st_lookup) begin
                refilled <= 1'b0;
            end
        end
    end

    always_comb begin
        state_next = state;
        accept     = 1'b0;
        cpu_ack    = 1'b0;
        mem_cyc    = 1'b0;
        mem_stb    = 1'b0;
        beat_clear = 1'b0;
        beat_inc   = 1'b0;
        hit_event  = 1'b0;
        miss_event = 1'b0;
        tag_write  = 1'b0;
        word_write = 1'b0;

        case (state)
            st_idle: begin
                if (cpu_cyc && cpu_stb) begin
                    accept     = 1'b1;
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                // held address is valid here, tag store answers in this cycle
                if (hit) begin
                    cpu_ack    = 1'b1;
                    hit_event  = !refilled;
                    state_next = st_idle;
                end else begin
                    miss_event = 1'b1;
                    beat_clear = 1'b1;
                    state_next = st_refill;
                end
            end
            st_refill: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                if (mem_ack) begin
                    word_write = 1'b1;
                    beat_inc   = 1'b1;
                    if (last_beat) begin
                        tag_write  = 1'b1;
                        state_next = st_lookup;
                    end else begin
                        state_next = st_refill_gap;
                    end
                end
            end
            st_refill_gap: begin
                // cyc stays up, stb drops for one cycle between beats
                mem_cyc    = 1'b1;
                state_next = st_refill;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // memory may only ack a live strobe, a stray ack would write a wrong word
    a_ack_on_stb: assert property (
        @(posedge clk) disable iff (reset_n)
        mem_ack |-> mem_stb
    );

    // the fetch master must hold its request until the ack
    a_ack_in_request: assert property (
        @(posedge clk) disable iff (reset_n)
        cpu_ack |-> (cpu_cyc && cpu_stb)
    );

endmodule

`default_nettype wire

// File: hw/icache_data_store.sv
`default_nettype none

module icache_data_store (
    input  logic                            clk,
    input  logic [icache_pkg::index_w-1:0]  index,
    input  logic [icache_pkg::offset_w-1:0] offset,
    input  logic [icache_pkg::offset_w-1:0] beat,
    input  logic                            word_write,
    input  logic [icache_pkg::word_w-1:0]   wdata,
    output logic [icache_pkg::word_w-1:0]   rdata
);
    import icache_pkg::*;

    logic [word_w-1:0] words [num_sets][block_words];

    // refill fills one word per beat at the held set
    always_ff @(posedge clk) begin
        if (word_write) begin
            words[index][beat] <= wdata;
        end
    end

    assign rdata = words[index][offset];

    // back to back writes would have to land on one beat, the counter advances per ack
    a_beat_steady: assert property (
        @(posedge clk)
        word_write ##1 word_write |-> $stable(beat)
    );

endmodule

`default_nettype wire

// File: hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // geometry of the fetch path
    localparam int word_w      = 16;
    localparam int tag_w       = 12;
    localparam int index_w     = 2;
    localparam int offset_w    = 2;
    localparam int num_sets    = 4;
    localparam int block_words = 4;

    // hit and miss tallies
    localparam int count_w = 16;

    // controller state codes
    localparam int          state_w       = 2;
    localparam logic [1:0]  st_idle       = 2'd0;
    localparam logic [1:0]  st_lookup     = 2'd1;
    localparam logic [1:0]  st_refill     = 2'd2;
    localparam logic [1:0]  st_refill_gap = 2'd3;

    // word address split, tag in the high bits
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } fetch_fields_t;

    typedef union packed {
        logic [word_w-1:0] raw;
        fetch_fields_t     f;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: hw/icache_tag_store.sv
`default_nettype none

module icache_tag_store (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [icache_pkg::index_w-1:0] index,
    input  logic [icache_pkg::tag_w-1:0]   tag,
    input  logic                           tag_write,
    output logic                           hit
);
    import icache_pkg::*;

    logic [num_sets-1:0] valid;
    logic [tag_w-1:0]    tags [num_sets];

    // valid bits are the only state that reset touches
    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid <= '0;
        end else if (tag_write) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[index] <= tag;
        end
    end

    // combinational compare against the held fetch address
    assign hit = valid[index] && (tags[index] == tag);

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`default_nettype none

module icache_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           cpu_cyc,
    input  logic                           cpu_stb,
    input  logic [icache_pkg::word_w-1:0]  cpu_adr,
    output logic                           cpu_ack,
    output logic [icache_pkg::word_w-1:0]  cpu_dat,
    output logic                           mem_cyc,
    output logic                           mem_stb,
    output logic [icache_pkg::word_w-1:0]  mem_adr,
    input  logic                           mem_ack,
    input  logic [icache_pkg::word_w-1:0]  mem_dat,
    output logic [icache_pkg::count_w-1:0] hit_count,
    output logic [icache_pkg::count_w-1:0] miss_count
);
    import icache_pkg::*;

    logic                accept;
    logic                hit;
    logic                beat_clear;
    logic                beat_inc;
    logic                hit_event;
    logic                miss_event;
    logic                tag_write;
    logic                word_write;
    logic                last_beat;
    logic [offset_w-1:0] beat;

    fetch_addr_u held_addr;
    fetch_addr_u refill_addr;

    // fetch address is captured once per request
    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr.raw <= cpu_adr;
        end
    end

    // block aligned refill, beats in offset order
    always_comb begin
        refill_addr.f.tag    = held_addr.f.tag;
        refill_addr.f.index  = held_addr.f.index;
        refill_addr.f.offset = beat;
    end

    assign mem_adr = refill_addr.raw;

    icache_ctrl i_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .cpu_cyc    (cpu_cyc),
        .cpu_stb    (cpu_stb),
        .hit        (hit),
        .mem_ack    (mem_ack),
        .last_beat  (last_beat),
        .accept     (accept),
        .cpu_ack    (cpu_ack),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .beat_clear (beat_clear),
        .beat_inc   (beat_inc),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .tag_write  (tag_write),
        .word_write (word_write)
    );

    icache_counters i_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .beat_clear (beat_clear),
        .beat_inc   (beat_inc),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .beat       (beat),
        .last_beat  (last_beat),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    icache_tag_store i_tag_store (
        .clk       (clk),
        .reset_n   (reset_n),
        .index     (held_addr.f.index),
        .tag       (held_addr.f.tag),
        .tag_write (tag_write),
        .hit       (hit)
    );

    icache_data_store i_data_store (
        .clk        (clk),
        .index      (held_addr.f.index),
        .offset     (held_addr.f.offset),
        .beat       (beat),
        .word_write (word_write),
        .wdata      (mem_dat),
        .rdata      (cpu_dat)
    );

endmodule

`default_nettype wire

// File: tests/icache_mem_model.sv
`default_nettype none

module icache_mem_model #(
    parameter int unsigned seed_init = 32'h1
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          mem_cyc,
    input  logic                          mem_stb,
    input  logic [icache_pkg::word_w-1:0] mem_adr,
    output logic                          mem_ack,
    output logic [icache_pkg::word_w-1:0] mem_dat
);
    timeunit 1ns;
    timeprecision 100ps;

    integer seed;
    logic   armed;
    int     wait_left;

    // instruction memory contents follow a fixed rule over the whole address
    function automatic logic [15:0] word_at(input logic [15:0] a);
        return a * 16'h9e37 + 16'h1234;
    endfunction

    initial seed = seed_init;

    // registered ack, 0 to 3 extra wait states drawn when a beat starts
    always @(posedge clk) begin
        if (reset_n) begin
            mem_ack <= 1'b0;
            armed   <= 1'b0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
            armed   <= 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!armed) begin
                armed     <= 1'b1;
                wait_left <= $unsigned($random(seed)) % 4;
            end else if (wait_left == 0) begin
                mem_ack <= 1'b1;
                mem_dat <= word_at(mem_adr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    localparam int          clk_period  = 20;
    localparam int          fetch_limit = 64;
    localparam int unsigned seed_value  = 32'h17d43c11;

    logic              clk;
    logic              reset_n;
    logic              cpu_cyc;
    logic              cpu_stb;
    logic [word_w-1:0] cpu_adr;
    logic              cpu_ack;
    logic [word_w-1:0] cpu_dat;
    logic              mem_cyc;
    logic              mem_stb;
    logic [word_w-1:0] mem_adr;
    logic              mem_ack;
    logic [word_w-1:0] mem_dat;
    logic [15:0]       hit_count;
    logic [15:0]       miss_count;

    integer seed;
    int     errors;
    int     checks;
    int     failed_tests;
    int     test_errors_start;

    // reference cache, one valid bit and tag per set
    logic             model_valid [1<<index_w];
    logic [tag_w-1:0] model_tag [1<<index_w];
    int               exp_hits;
    int               exp_misses;

    // memory side activity seen during the current fetch
    logic              cyc_seen;
    logic              beat_done;
    logic [word_w-1:0] beat_adrs [$];

    icache_top i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .cpu_cyc    (cpu_cyc),
        .cpu_stb    (cpu_stb),
        .cpu_adr    (cpu_adr),
        .cpu_ack    (cpu_ack),
        .cpu_dat    (cpu_dat),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .mem_adr    (mem_adr),
        .mem_ack    (mem_ack),
        .mem_dat    (mem_dat),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    icache_mem_model #(
        .seed_init (seed_value ^ 32'h0000_ffff)
    ) i_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .mem_cyc (mem_cyc),
        .mem_stb (mem_stb),
        .mem_adr (mem_adr),
        .mem_ack (mem_ack),
        .mem_dat (mem_dat)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_cyc) begin
            cyc_seen = 1'b1;
        end
        // stb has to drop for one cycle after every beat
        if (beat_done) begin
            compare_value("mem_stb after ack", mem_stb, 1'b0);
        end
        beat_done = mem_cyc && mem_stb && mem_ack;
        if (beat_done) begin
            beat_adrs.push_back(mem_adr);
        end
    end

    function automatic logic [word_w-1:0] expected_word(input logic [word_w-1:0] a);
        return a * 16'h9e37 + 16'h1234;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
        for (int s = 0; s < (1 << index_w); s++) begin
            model_valid[s] = 1'b0;
        end
        exp_hits   = 0;
        exp_misses = 0;
    endtask

    task automatic fetch_and_check(input logic [word_w-1:0] a);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        logic               expect_hit;
        logic [word_w-1:0]  data;
        int                 cycles;
        bit                 got;
        idx        = a[offset_w +: index_w];
        tag        = a[word_w-1 -: tag_w];
        expect_hit = model_valid[idx] && (model_tag[idx] == tag);
        @(posedge clk);
        cyc_seen = 1'b0;
        beat_adrs.delete();
        cpu_cyc <= 1'b1;
        cpu_stb <= 1'b1;
        cpu_adr <= a;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < fetch_limit) begin
            @(posedge clk);
            cycles++;
            if (cpu_ack) begin
                got  = 1'b1;
                data = cpu_dat;
            end
        end
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        if (!got) begin
            $display("timeout: no cpu_ack within %0d cycles for fetch of %h", fetch_limit, a);
            $display("Test failures found");
            $finish;
        end else begin
            compare_value("cpu_dat", data, expected_word(a));
            compare_value("mem_cyc active", cyc_seen, !expect_hit);
            if (expect_hit) begin
                exp_hits++;
                // ack in the second cycle of stb
                compare_value("cpu_ack cycle", cycles, 2);
            end else begin
                exp_misses++;
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
                compare_value("refill beats", beat_adrs.size(), 1 << offset_w);
                for (int i = 0; i < beat_adrs.size() && i < (1 << offset_w); i++) begin
                    compare_value("mem_adr", beat_adrs[i], {tag, idx, offset_w'(i)});
                end
            end
        end
    endtask

    task automatic check_tallies();
        @(negedge clk);
        compare_value("hit_count", hit_count, exp_hits);
        compare_value("miss_count", miss_count, exp_misses);
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    initial begin
        logic [31:0]       r;
        logic [word_w-1:0] a;
        seed              = seed_value;
        reset_n           = 1'b1;
        cpu_cyc           = 1'b0;
        cpu_stb           = 1'b0;
        cpu_adr           = '0;
        beat_done         = 1'b0;
        errors            = 0;
        checks            = 0;
        failed_tests      = 0;
        test_errors_start = 0;
        apply_reset();

        fetch_and_check(16'h0123);
        check_tallies();
        report_test("cold_miss");

        // rest of the block just filled
        fetch_and_check(16'h0120);
        fetch_and_check(16'h0121);
        fetch_and_check(16'h0122);
        check_tallies();
        report_test("block_hits");

        // same set 0, other tag, then back again
        fetch_and_check(16'h4563);
        fetch_and_check(16'h0123);
        check_tallies();
        report_test("conflict_eviction");

        // four tags over all sets, so hits and misses mix
        a = '0;
        repeat (200) begin
            r = $random(seed);
            a = {10'h2c3, r[5:0]};
            fetch_and_check(a);
        end
        check_tallies();
        report_test("random_stream");

        apply_reset();
        check_tallies();
        fetch_and_check(a);
        check_tallies();
        report_test("reset_invalidation");

        $display("tests: 5, failed: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
